//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [63:0]     inst_id_t;

    typedef enum logic [3:0] {
        WB_ALU   = 4'd0,
        WB_MEMB  = 4'd1,
        WB_MEMBU = 4'd2,
        WB_MEMH  = 4'd3,
        WB_MEMHU = 4'd4,
        WB_MEMW  = 4'd5,
        WB_PC    = 4'd6,
        WB_CSR   = 4'd7
    } wb_sel_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic      rf_wen;
        wb_sel_e   wb_sel;
        reg_addr_t wb_addr;
        mem_op_e   mem_op;
        mem_size_e mem_size;
    } ctrl_t;

    localparam int RAM_WORDS = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

    localparam xlen_t    EXIT_PC       = 32'hffffff00;
    localparam inst_id_t INST_ID_RESET = 64'hffff000000000000;

endpackage

`default_nettype wire

//--- verilog/wb_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface wb_bus_if;
    import core_pkg::*;

    logic     valid;
    xlen_t    pc;
    inst_id_t inst_id;
    ctrl_t    ctrl;
    xlen_t    alu_out;
    xlen_t    mem_rdata;
    xlen_t    csr_rdata;

    // Memory stage owns the write-back register
    modport source (
        output valid, pc, inst_id, ctrl, alu_out, mem_rdata, csr_rdata
    );

    modport sink (
        input valid, pc, inst_id, ctrl, alu_out, mem_rdata, csr_rdata
    );

endinterface

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire                 valid_i,
    input  core_pkg::xlen_t     pc_i,
    input  core_pkg::inst_id_t  inst_id_i,
    input  core_pkg::ctrl_t     ctrl_i,
    input  core_pkg::xlen_t     alu_out_i,
    input  core_pkg::xlen_t     store_data_i,
    input  core_pkg::xlen_t     csr_rdata_i,
    output logic                ready_o,
    output core_pkg::xlen_t     paddr_o,
    output logic                psel_o,
    output logic                penable_o,
    output logic                pwrite_o,
    output core_pkg::xlen_t     pwdata_o,
    output logic [3:0]          pstrb_o,
    input  core_pkg::xlen_t     prdata_i,
    input  wire                 pready_i,
    wb_bus_if.source            wb
);
    import core_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS} state_e;

    state_e   state;
    xlen_t    req_pc;
    inst_id_t req_id;
    ctrl_t    req_ctrl;
    xlen_t    req_alu;
    xlen_t    req_sd;
    xlen_t    req_csr;
    logic     accept;
    logic     is_mem;

    assign ready_o = (state == ST_IDLE);
    assign accept = valid_i && ready_o;
    assign is_mem = (ctrl_i.mem_op == MEM_LOAD) || (ctrl_i.mem_op == MEM_STORE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= ST_IDLE;
            wb.valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept && is_mem) begin
                        state <= ST_SETUP;
                    end else if (accept) begin
                        wb.valid <= 1'b1;
                    end
                end
                ST_SETUP: state <= ST_ACCESS;
                ST_ACCESS: begin
                    if (pready_i) begin
                        state <= ST_IDLE;
                        wb.valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request latch for memory ops and the write-back payload
    always_ff @(posedge clk) begin
        if (accept && is_mem) begin
            req_pc <= pc_i;
            req_id <= inst_id_i;
            req_ctrl <= ctrl_i;
            req_alu <= alu_out_i;
            req_sd <= store_data_i;
            req_csr <= csr_rdata_i;
        end
        if (accept && !is_mem) begin
            wb.pc <= pc_i;
            wb.inst_id <= inst_id_i;
            wb.ctrl <= ctrl_i;
            wb.alu_out <= alu_out_i;
            wb.mem_rdata <= '0;
            wb.csr_rdata <= csr_rdata_i;
        end else if (state == ST_ACCESS && pready_i) begin
            wb.pc <= req_pc;
            wb.inst_id <= req_id;
            wb.ctrl <= req_ctrl;
            wb.alu_out <= req_alu;
            wb.mem_rdata <= prdata_i;
            wb.csr_rdata <= req_csr;
        end
    end

    assign psel_o = (state != ST_IDLE);
    assign penable_o = (state == ST_ACCESS);
    assign pwrite_o = (req_ctrl.mem_op == MEM_STORE);
    assign paddr_o = {req_alu[31:2], 2'b00};

    always_comb begin
        case (req_ctrl.mem_size)
            SIZE_B: begin
                pwdata_o = {4{req_sd[7:0]}};
                pstrb_o = 4'b0001 << req_alu[1:0];
            end
            SIZE_H: begin
                pwdata_o = {2{req_sd[15:0]}};
                pstrb_o = req_alu[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                pwdata_o = req_sd;
                pstrb_o = 4'b1111;
            end
        endcase
        // Reads carry no strobes on APB
        if (!pwrite_o) begin
            pstrb_o = 4'b0000;
        end
    end

    a_apb_stable: assert property (@(posedge clk) disable iff (reset_i)
        (penable_o && !pready_i) |=>
            (psel_o && $stable(paddr_o) && $stable(pwrite_o) &&
             $stable(pwdata_o) && $stable(pstrb_o)));

    a_busy_no_accept: assert property (@(posedge clk) disable iff (reset_i)
        (psel_o && !(penable_o && pready_i)) |=> !ready_o);

endmodule

`default_nettype wire

//--- verilog/apb_data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module apb_data_ram (
    input  wire              clk,
    input  wire              reset_i,
    input  core_pkg::xlen_t  paddr_i,
    input  wire              psel_i,
    input  wire              penable_i,
    input  wire              pwrite_i,
    input  core_pkg::xlen_t  pwdata_i,
    input  wire [3:0]        pstrb_i,
    output core_pkg::xlen_t  prdata_o,
    output logic             pready_o
);
    import core_pkg::*;

    xlen_t                 mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0] word_idx;
    logic                  setup_phase;
    logic                  access_phase;

    assign word_idx = paddr_i[RAM_ADDR_W+1:2];
    assign setup_phase = psel_i && !penable_i;
    assign access_phase = psel_i && penable_i;

    // Zero wait states
    assign pready_o = access_phase;

    always_ff @(posedge clk) begin
        if (access_phase && pwrite_i) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb_i[b]) begin
                    mem[word_idx][8*b +: 8] <= pwdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read data is captured at the end of setup and held through access
    always_ff @(posedge clk) begin
        if (reset_i) begin
            prdata_o <= '0;
        end else if (setup_phase && !pwrite_i) begin
            prdata_o <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  wire                 clk,
    input  wire                 reset_i,
    wb_bus_if.sink              wb,
    output logic                rf_we_o,
    output core_pkg::reg_addr_t rf_waddr_o,
    output core_pkg::xlen_t     rf_wdata_o,
    output core_pkg::xlen_t     inst_count_o,
    output logic                exit_o
);
    import core_pkg::*;

    inst_id_t saved_id;
    logic     is_new_inst;
    xlen_t    wb_data;

    function automatic xlen_t wb_data_f(
        input xlen_t   pc,
        input wb_sel_e sel,
        input xlen_t   alu,
        input xlen_t   csr,
        input xlen_t   rdata
    );
        logic [7:0]  byte_lane;
        logic [15:0] half_lane;
        // Low address bits pick the lane inside the loaded word
        byte_lane = rdata[{alu[1:0], 3'b000} +: 8];
        half_lane = alu[1] ? rdata[31:16] : rdata[15:0];
        case (sel)
            WB_MEMB:  wb_data_f = {{24{byte_lane[7]}}, byte_lane};
            WB_MEMBU: wb_data_f = {24'b0, byte_lane};
            WB_MEMH:  wb_data_f = {{16{half_lane[15]}}, half_lane};
            WB_MEMHU: wb_data_f = {16'b0, half_lane};
            WB_MEMW:  wb_data_f = rdata;
            WB_PC:    wb_data_f = pc + 32'd4;
            WB_CSR:   wb_data_f = csr;
            default:  wb_data_f = alu;
        endcase
    endfunction

    assign wb_data = wb_data_f(wb.pc, wb.ctrl.wb_sel, wb.alu_out, wb.csr_rdata,
                               wb.mem_rdata);

    // The bus keeps presenting the last instruction, so only a fresh id commits
    assign is_new_inst = wb.valid && (wb.inst_id != saved_id);

    assign rf_we_o = is_new_inst && wb.ctrl.rf_wen;
    assign rf_waddr_o = wb.ctrl.wb_addr;
    assign rf_wdata_o = wb_data;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            saved_id <= INST_ID_RESET;
            inst_count_o <= '0;
            exit_o <= 1'b0;
        end else begin
            if (wb.valid) begin
                saved_id <= wb.inst_id;
            end
            if (is_new_inst) begin
                inst_count_o <= inst_count_o + 32'd1;
            end
            if (is_new_inst && wb.pc == EXIT_PC) begin
                exit_o <= 1'b1;
            end
        end
    end

    a_write_retires: assert property (@(posedge clk) disable iff (reset_i)
        rf_we_o |=> (inst_count_o == $past(inst_count_o) + 32'd1));

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire                 we_i,
    input  core_pkg::reg_addr_t waddr_i,
    input  core_pkg::xlen_t     wdata_i,
    input  core_pkg::reg_addr_t raddr_a_i,
    output core_pkg::xlen_t     rdata_a_o,
    input  core_pkg::reg_addr_t raddr_b_i,
    output core_pkg::xlen_t     rdata_b_o
);
    import core_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is never written, but force zero on read as well
    assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

//--- verilog/core_backend.sv
`timescale 1ns/1ns
`default_nettype none

module core_backend (
    input  wire                 clk,
    input  wire                 reset_i,
    input  wire                 valid_i,
    output logic                ready_o,
    input  core_pkg::xlen_t     pc_i,
    input  core_pkg::inst_id_t  inst_id_i,
    input  wire                 rf_wen_i,
    input  core_pkg::wb_sel_e   wb_sel_i,
    input  core_pkg::reg_addr_t wb_addr_i,
    input  core_pkg::mem_op_e   mem_op_i,
    input  core_pkg::mem_size_e mem_size_i,
    input  core_pkg::xlen_t     alu_out_i,
    input  core_pkg::xlen_t     store_data_i,
    input  core_pkg::xlen_t     csr_rdata_i,
    input  core_pkg::reg_addr_t rs1_addr_i,
    output core_pkg::xlen_t     rs1_data_o,
    input  core_pkg::reg_addr_t rs2_addr_i,
    output core_pkg::xlen_t     rs2_data_o,
    output core_pkg::xlen_t     inst_count_o,
    output logic                exit_o
);
    import core_pkg::*;

    ctrl_t     ctrl;
    xlen_t     paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    xlen_t     pwdata;
    logic [3:0] pstrb;
    xlen_t     prdata;
    logic      pready;
    logic      rf_we;
    reg_addr_t rf_waddr;
    xlen_t     rf_wdata;

    assign ctrl = '{rf_wen: rf_wen_i, wb_sel: wb_sel_i, wb_addr: wb_addr_i,
                    mem_op: mem_op_i, mem_size: mem_size_i};

    wb_bus_if wb_bus ();

    mem_stage u_mem_stage (
        .clk(clk), .reset_i(reset_i), .valid_i(valid_i), .pc_i(pc_i),
        .inst_id_i(inst_id_i), .ctrl_i(ctrl), .alu_out_i(alu_out_i),
        .store_data_i(store_data_i), .csr_rdata_i(csr_rdata_i), .ready_o(ready_o),
        .paddr_o(paddr), .psel_o(psel), .penable_o(penable), .pwrite_o(pwrite),
        .pwdata_o(pwdata), .pstrb_o(pstrb), .prdata_i(prdata), .pready_i(pready),
        .wb(wb_bus.source)
    );

    apb_data_ram u_ram (
        .clk(clk), .reset_i(reset_i), .paddr_i(paddr), .psel_i(psel),
        .penable_i(penable), .pwrite_i(pwrite), .pwdata_i(pwdata),
        .pstrb_i(pstrb), .prdata_o(prdata), .pready_o(pready)
    );

    writeback_stage u_wb_stage (
        .clk(clk), .reset_i(reset_i), .wb(wb_bus.sink), .rf_we_o(rf_we),
        .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .inst_count_o(inst_count_o), .exit_o(exit_o)
    );

    register_file u_regfile (
        .clk(clk), .reset_i(reset_i), .we_i(rf_we), .waddr_i(rf_waddr),
        .wdata_i(rf_wdata), .raddr_a_i(rs1_addr_i), .rdata_a_o(rs1_data_o),
        .raddr_b_i(rs2_addr_i), .rdata_b_o(rs2_data_o)
    );

endmodule

`default_nettype wire

//--- verification/backend_tb.sv
`timescale 1ns/1ns
`default_nettype none

module backend_tb;
    import core_pkg::*;

    // Roughly 750 cycles of traffic and register reads, with margin on top
    localparam int MAX_CYCLES = 2000;

    logic      clk = 1'b0;
    logic      reset_i;
    logic      valid_i;
    logic      ready_o;
    xlen_t     pc_i;
    inst_id_t  inst_id_i;
    logic      rf_wen_i;
    wb_sel_e   wb_sel_i;
    reg_addr_t wb_addr_i;
    mem_op_e   mem_op_i;
    mem_size_e mem_size_i;
    xlen_t     alu_out_i;
    xlen_t     store_data_i;
    xlen_t     csr_rdata_i;
    reg_addr_t rs1_addr_i;
    xlen_t     rs1_data_o;
    reg_addr_t rs2_addr_i;
    xlen_t     rs2_data_o;
    xlen_t     inst_count_o;
    logic      exit_o;

    // Reference model state
    xlen_t    model_regs [32];
    xlen_t    model_mem [RAM_WORDS];
    xlen_t    model_count;
    inst_id_t next_id;
    integer   seed;
    int       cycles = 0;
    string    test_name;
    wb_sel_e  load_sels [5] = '{WB_MEMB, WB_MEMBU, WB_MEMH, WB_MEMHU, WB_MEMW};

    core_backend uut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s count: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic xlen_t rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic xlen_t next_pc();
        next_pc = 32'h0000_1000 + {next_id[29:0], 2'b00};
    endfunction

    // Value the write-back stage should deliver, from the model memory
    function automatic xlen_t expected_wb(input wb_sel_e sel, input xlen_t pc,
                                          input xlen_t alu, input xlen_t csr);
        xlen_t       word;
        logic [7:0]  byte_v;
        logic [15:0] half_v;
        word = model_mem[alu[9:2]];
        byte_v = 8'(word >> (8 * alu[1:0]));
        half_v = 16'(word >> (16 * alu[1]));
        case (sel)
            WB_MEMB:  expected_wb = 32'($signed(byte_v));
            WB_MEMBU: expected_wb = 32'(byte_v);
            WB_MEMH:  expected_wb = 32'($signed(half_v));
            WB_MEMHU: expected_wb = 32'(half_v);
            WB_MEMW:  expected_wb = word;
            WB_PC:    expected_wb = pc + 32'd4;
            WB_CSR:   expected_wb = csr;
            default:  expected_wb = alu;
        endcase
    endfunction

    function automatic void model_store(input xlen_t addr, input mem_size_e size,
                                        input xlen_t data);
        case (size)
            SIZE_B:  model_mem[addr[9:2]][8 * addr[1:0] +: 8] = data[7:0];
            SIZE_H:  model_mem[addr[9:2]][16 * addr[1] +: 16] = data[15:0];
            default: model_mem[addr[9:2]] = data;
        endcase
    endfunction

    // Holds one instruction on the inputs until the DUT accepts it
    task automatic present(input inst_id_t id, input xlen_t pc, input logic wen,
                           input wb_sel_e sel, input reg_addr_t rd, input mem_op_e op,
                           input mem_size_e size, input xlen_t alu, input xlen_t sd,
                           input xlen_t csr);
        inst_id_i = id;
        pc_i = pc;
        rf_wen_i = wen;
        wb_sel_i = sel;
        wb_addr_i = rd;
        mem_op_i = op;
        mem_size_i = size;
        alu_out_i = alu;
        store_data_i = sd;
        csr_rdata_i = csr;
        valid_i = 1'b1;
        while (!ready_o) @(negedge clk);
        @(negedge clk);
        valid_i = 1'b0;
        // A memory op holds off the next instruction during its APB transfer
        check_flag($sformatf("%s ready_o", test_name), op == MEM_NONE, ready_o);
    endtask

    task automatic run_inst(input xlen_t pc, input logic wen, input wb_sel_e sel,
                            input reg_addr_t rd, input mem_op_e op, input mem_size_e size,
                            input xlen_t alu, input xlen_t sd, input xlen_t csr);
        next_id = next_id + 64'd1;
        present(next_id, pc, wen, sel, rd, op, size, alu, sd, csr);
        if (op == MEM_STORE) begin
            model_store(alu, size, sd);
        end else if (wen && rd != 5'd0) begin
            model_regs[rd] = expected_wb(sel, pc, alu, csr);
        end
        model_count = model_count + 32'd1;
    endtask

    task automatic alu_op(input reg_addr_t rd, input wb_sel_e sel, input xlen_t val,
                          input xlen_t csr);
        run_inst(next_pc(), 1'b1, sel, rd, MEM_NONE, SIZE_W, val, '0, csr);
    endtask

    task automatic store_op(input xlen_t addr, input mem_size_e size, input xlen_t data);
        run_inst(next_pc(), 1'b0, WB_ALU, 5'd0, MEM_STORE, size, addr, data, '0);
    endtask

    task automatic load_op(input reg_addr_t rd, input xlen_t addr, input wb_sel_e sel);
        run_inst(next_pc(), 1'b1, sel, rd, MEM_LOAD, SIZE_W, addr, '0, '0);
    endtask

    // Waits until the last accepted instruction has written the register file
    task automatic settle();
        while (!ready_o) @(negedge clk);
        @(negedge clk);
    endtask

    // Port b reads the mirrored index so both read ports see every register
    task automatic read_reg(input reg_addr_t rd);
        reg_addr_t rd_b;
        rd_b = ~rd;
        rs1_addr_i = rd;
        rs2_addr_i = rd_b;
        #1;
        check_word($sformatf("%s x%0d", test_name, rd), model_regs[rd], rs1_data_o);
        check_word($sformatf("%s rs2 x%0d", test_name, rd_b), model_regs[rd_b], rs2_data_o);
        @(negedge clk);
    endtask

    task automatic check_regs();
        settle();
        for (int i = 0; i < 32; i++) begin
            read_reg(5'(i));
        end
        check_count(test_name, model_count, inst_count_o);
    endtask

    task automatic check_load(input xlen_t addr, input wb_sel_e sel);
        load_op(5'd9, addr, sel);
        settle();
        read_reg(5'd9);
    endtask

    initial begin
        xlen_t r;
        xlen_t addr;
        seed = 32'h1f16_14f6;
        reset_i = 1'b1;
        valid_i = 1'b0;
        pc_i = '0;
        inst_id_i = '0;
        rf_wen_i = 1'b0;
        wb_sel_i = WB_ALU;
        wb_addr_i = '0;
        mem_op_i = MEM_NONE;
        mem_size_i = SIZE_W;
        alu_out_i = '0;
        store_data_i = '0;
        csr_rdata_i = '0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        next_id = 64'd0;
        model_count = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        test_name = "alu_pc_writes";
        alu_op(5'd0, WB_ALU, rand_word(), '0);
        for (int i = 0; i < 12; i++) begin
            r = rand_word();
            alu_op(r[4:0], r[5] ? WB_PC : WB_ALU, rand_word(), '0);
        end
        check_regs();

        test_name = "store_load_sizes";
        for (int w = 0; w < 4; w++) begin
            store_op(32'h40 + 4 * w, SIZE_W, rand_word());
        end
        store_op(32'h48, SIZE_H, rand_word());
        store_op(32'h4a, SIZE_H, rand_word());
        store_op(32'h45, SIZE_B, rand_word());
        for (int b = 0; b < 4; b++) begin
            store_op(32'h4c + b, SIZE_B, rand_word());
        end
        for (int a = 0; a < 16; a++) begin
            addr = 32'h40 + a;
            if (a % 4 == 0) check_load(addr, WB_MEMW);
            if (a % 2 == 0) begin
                check_load(addr, WB_MEMH);
                check_load(addr, WB_MEMHU);
            end
            check_load(addr, WB_MEMB);
            check_load(addr, WB_MEMBU);
        end
        check_count(test_name, model_count, inst_count_o);

        test_name = "csr_and_no_write";
        alu_op(5'd3, WB_CSR, rand_word(), rand_word());
        run_inst(next_pc(), 1'b0, WB_ALU, 5'd3, MEM_NONE, SIZE_W, rand_word(), '0, '0);
        check_regs();

        test_name = "duplicate_id";
        next_id = next_id + 64'd1;
        r = rand_word();
        present(next_id, next_pc(), 1'b1, WB_ALU, 5'd4, MEM_NONE, SIZE_W, r, '0, '0);
        present(next_id, next_pc(), 1'b1, WB_ALU, 5'd4, MEM_NONE, SIZE_W, ~r, '0, '0);
        model_regs[4] = r;
        model_count = model_count + 32'd1;
        settle();
        check_count(test_name, model_count, inst_count_o);
        alu_op(5'd5, WB_ALU, rand_word(), '0);
        check_regs();

        test_name = "exit";
        check_flag($sformatf("%s exit_o", test_name), 1'b0, exit_o);
        run_inst(EXIT_PC, 1'b1, WB_PC, 5'd6, MEM_NONE, SIZE_W, rand_word(), '0, '0);
        settle();
        check_flag($sformatf("%s exit_o", test_name), 1'b1, exit_o);
        check_count(test_name, model_count, inst_count_o);

        test_name = "back_to_back_mix";
        for (int w = 0; w < 8; w++) begin
            store_op(32'h80 + 4 * w, SIZE_W, rand_word());
        end
        for (int i = 0; i < 40; i++) begin
            r = rand_word();
            addr = 32'h80 + r[4:0];
            case (r[9:8])
                2'd0: alu_op(r[14:10], WB_ALU, rand_word(), '0);
                2'd1: store_op(addr, r[11] ? SIZE_H : (r[10] ? SIZE_B : SIZE_W), rand_word());
                2'd2: load_op(r[14:10], addr, load_sels[r[18:16] % 3'd5]);
                default: alu_op(r[14:10], WB_PC, rand_word(), '0);
            endcase
        end
        check_regs();
        for (int w = 0; w < 8; w++) begin
            check_load(32'h80 + 4 * w, WB_MEMW);
        end
        check_count(test_name, model_count, inst_count_o);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/core_pkg.sv
verilog/wb_bus_if.sv
verilog/mem_stage.sv
verilog/apb_data_ram.sv
verilog/writeback_stage.sv
verilog/register_file.sv
verilog/core_backend.sv
verification/backend_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module backend_tb -f project.f -o backend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/backend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
